// ==== include/float_mul_macros.svh ====
`ifndef FLOAT_MUL_MACROS_SVH
`define FLOAT_MUL_MACROS_SVH

// ieee 754 single precision layout
`define FLOAT_WIDTH 32
`define EXP_WIDTH   8
`define MANT_WIDTH  23

// significand with the hidden one
`define SIG_WIDTH   24

`define EXP_BIAS    127

// wide enough to count 0..SIG_WIDTH skipped multiplier bits
`define SKIP_WIDTH  5

`endif

// ==== logic/float_mul_pkg.sv ====
`include "float_mul_macros.svh"

package float_mul_pkg;

    typedef struct packed {
        logic                    sign;
        logic [`EXP_WIDTH-1:0]   exp;
        logic [`MANT_WIDTH-1:0]  frac;
    } float_t;

    // operand pair after field split, held for the whole operation
    typedef struct packed {
        logic [`SIG_WIDTH-1:0]        a_sig;
        logic [`SIG_WIDTH-1:0]        b_sig;
        logic                         sign;
        // two extra bits so the biased sum cannot wrap
        logic signed [`EXP_WIDTH+1:0] exp_sum;
        logic                         is_zero;
    } operand_t;

    typedef struct packed {
        logic [2*`SIG_WIDTH-1:0] raw;
        // trailing multiplier bits never visited by the loop
        logic [`SKIP_WIDTH-1:0]  skipped;
    } product_t;

    typedef enum logic [2:0] {
        st_idle,
        st_decode,
        st_multiply,
        st_normalize,
        st_done
    } mul_state_e;

endpackage

// ==== logic/float_mul_control.sv ====
`timescale 1ns/1ps

module float_mul_control
    import float_mul_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic req,
    input  logic is_zero,
    input  logic mul_done,
    output logic capture,
    output logic start,
    output logic load_zero,
    output logic load_product,
    output logic ack
);

    mul_state_e state;
    mul_state_e state_next;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (req) begin
                    state_next = st_decode;
                end
            end
            // decode fields valid one cycle after capture
            st_decode: begin
                if (is_zero) begin
                    state_next = st_normalize;
                end else begin
                    state_next = st_multiply;
                end
            end
            st_multiply: begin
                if (mul_done) begin
                    state_next = st_normalize;
                end
            end
            // out already registered on the edge into this state
            st_normalize: begin
                state_next = st_done;
            end
            st_done: begin
                state_next = st_idle;
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    // strobes decoded from state
    // a req outside idle is simply dropped
    always_comb begin
        capture      = (state == st_idle) && req;
        load_zero    = (state == st_decode) && is_zero;
        start        = (state == st_decode) && !is_zero;
        load_product = (state == st_multiply) && mul_done;
        ack          = (state == st_done);
    end

endmodule

// ==== logic/float_operand_decode.sv ====
`timescale 1ns/1ps
`include "float_mul_macros.svh"

module float_operand_decode
    import float_mul_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     capture,
    input  float_t   a,
    input  float_t   b,
    output operand_t operands
);

    logic signed [`EXP_WIDTH+1:0] exp_sum_next;
    logic                         zero_next;

    // biased sum, one bias removed so the result is biased once
    assign exp_sum_next = $signed({2'b00, a.exp}) + $signed({2'b00, b.exp})
                          - $signed((`EXP_WIDTH+2)'(`EXP_BIAS));

    // exponent field of zero means zero, denormals flushed too
    assign zero_next = (a.exp == '0) || (b.exp == '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            operands <= '0;
        end else if (capture) begin
            operands.a_sig   <= {1'b1, a.frac};
            operands.b_sig   <= {1'b1, b.frac};
            operands.sign    <= a.sign ^ b.sign;
            operands.exp_sum <= exp_sum_next;
            operands.is_zero <= zero_next;
        end
    end

endmodule

// ==== logic/significand_shift_mul.sv ====
`timescale 1ns/1ps
`include "float_mul_macros.svh"

module significand_shift_mul
    import float_mul_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  logic [`SIG_WIDTH-1:0] multiplicand,
    input  logic [`SIG_WIDTH-1:0] multiplier,
    output logic                  mul_done,
    output product_t              product
);

    logic                    busy;
    logic [`SKIP_WIDTH-1:0]  iter_cnt;
    logic [`SIG_WIDTH-1:0]   mplier_sr;
    logic [2*`SIG_WIDTH-1:0] acc;
    logic                    bits_left;

    // nothing left to visit once the remaining bits are all zero
    assign bits_left = (mplier_sr != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            mul_done <= 1'b0;
            iter_cnt <= '0;
        end else begin
            mul_done <= 1'b0;
            if (start) begin
                busy     <= 1'b1;
                iter_cnt <= '0;
            end else if (busy) begin
                if (bits_left) begin
                    iter_cnt <= iter_cnt + 1'b1;
                end else begin
                    busy     <= 1'b0;
                    mul_done <= 1'b1;
                end
            end
        end
    end

    // msb first, so the accumulator doubles every step
    // multiplicand is held by decode for the whole operation
    always_ff @(posedge clk) begin
        if (start) begin
            acc       <= '0;
            mplier_sr <= multiplier;
        end else if (busy && bits_left) begin
            if (mplier_sr[`SIG_WIDTH-1]) begin
                acc <= {acc[2*`SIG_WIDTH-2:0], 1'b0} + {{`SIG_WIDTH{1'b0}}, multiplicand};
            end else begin
                acc <= {acc[2*`SIG_WIDTH-2:0], 1'b0};
            end
            mplier_sr <= {mplier_sr[`SIG_WIDTH-2:0], 1'b0};
        end
    end

    // acc holds the product of the visited bits only
    // normalize shifts it back by the skipped count
    always_comb begin
        product.raw     = acc;
        product.skipped = `SKIP_WIDTH'(`SIG_WIDTH) - iter_cnt;
    end

endmodule

// ==== logic/float_normalize_pack.sv ====
`timescale 1ns/1ps
`include "float_mul_macros.svh"

module float_normalize_pack
    import float_mul_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     load_zero,
    input  logic     load_product,
    input  operand_t operands,
    input  product_t product,
    output float_t   out
);

    logic [2*`SIG_WIDTH-1:0] full_prod;
    logic [`MANT_WIDTH-1:0]  frac_next;
    logic [`EXP_WIDTH+1:0]   exp_next;

    always_comb begin
        // restore the weight of the skipped trailing zeros
        full_prod = product.raw << product.skipped;
        // product of two 1.x values lies in [1, 4)
        if (full_prod[2*`SIG_WIDTH-1]) begin
            frac_next = full_prod[2*`SIG_WIDTH-2 -: `MANT_WIDTH];
            exp_next  = operands.exp_sum + 1'b1;
        end else begin
            frac_next = full_prod[2*`SIG_WIDTH-3 -: `MANT_WIDTH];
            exp_next  = operands.exp_sum;
        end
    end

    // lower bits dropped, i.e. round toward zero
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out <= '0;
        end else if (load_zero) begin
            out.sign <= operands.sign;
            out.exp  <= '0;
            out.frac <= '0;
        end else if (load_product) begin
            out.sign <= operands.sign;
            out.exp  <= exp_next[`EXP_WIDTH-1:0];
            out.frac <= frac_next;
        end
    end

endmodule

// ==== logic/float_mul_pipeline.sv ====
`timescale 1ns/1ps

module float_mul_pipeline
    import float_mul_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   req,
    input  float_t a,
    input  float_t b,
    output logic   ack,
    output float_t out
);

    logic     capture;
    logic     start;
    logic     load_zero;
    logic     load_product;
    logic     mul_done;
    operand_t operands;
    product_t product;

    float_mul_control u_control (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .is_zero      (operands.is_zero),
        .mul_done     (mul_done),
        .capture      (capture),
        .start        (start),
        .load_zero    (load_zero),
        .load_product (load_product),
        .ack          (ack)
    );

    float_operand_decode u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .capture  (capture),
        .a        (a),
        .b        (b),
        .operands (operands)
    );

    // one operation in flight at a time, latency depends on b
    significand_shift_mul u_mul (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .multiplicand (operands.a_sig),
        .multiplier   (operands.b_sig),
        .mul_done     (mul_done),
        .product      (product)
    );

    float_normalize_pack u_normalize (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_zero    (load_zero),
        .load_product (load_product),
        .operands     (operands),
        .product      (product),
        .out          (out)
    );

endmodule

// ==== verification/float_mul_model.svh ====
`ifndef FLOAT_MUL_MODEL_SVH
`define FLOAT_MUL_MODEL_SVH

// truncating single precision multiply, exponent field of zero is zero
function automatic logic [31:0] model_multiply(input logic [31:0] x, input logic [31:0] y);
    logic        sign;
    logic [7:0]  ex;
    logic [7:0]  ey;
    logic [47:0] prod;
    logic [9:0]  exp_res;
    logic [22:0] frac_res;
    sign = x[31] ^ y[31];
    ex   = x[30:23];
    ey   = y[30:23];
    if (ex == 8'd0 || ey == 8'd0) begin
        return {sign, 31'h0};
    end
    prod    = {24'h0, 1'b1, x[22:0]} * {24'h0, 1'b1, y[22:0]};
    exp_res = {2'b00, ex} + {2'b00, ey} - 10'd127;
    // product of two 1.x values is below 4, one carry at most
    if (prod[47]) begin
        frac_res = prod[46:24];
        exp_res  = exp_res + 10'd1;
    end else begin
        frac_res = prod[45:23];
    end
    return {sign, exp_res[7:0], frac_res};
endfunction

// double to single by field slicing, fraction truncated
function automatic logic [31:0] real_to_single(input real value);
    logic [63:0] d;
    logic [10:0] e;
    d = $realtobits(value);
    e = d[62:52];
    return {d[63], 8'(e - 11'd896), d[51:29]};
endfunction

`endif

// ==== verification/float_mul_tb.sv ====
`timescale 1ns/1ps
`include "float_mul_macros.svh"

module float_mul_tb
    import float_mul_pkg::*;
();

    localparam int TXN_LIMIT      = 300;
    localparam int CYCLES_PER_TXN = 40;

    logic   clk;
    logic   rst_n;
    logic   req;
    float_t a;
    float_t b;
    logic   ack;
    float_t out;

    logic [31:0] rng_state   = 32'h4aca_da43;
    int          errors      = 0;
    int          checks      = 0;
    int          cycle_count = 0;
    float_t      held_out    = '0;
    logic        out_moved   = 1'b0;

    `include "float_mul_model.svh"

    float_mul_pipeline uut (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .a     (a),
        .b     (b),
        .ack   (ack),
        .out   (out)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        while (cycle_count < TXN_LIMIT * CYCLES_PER_TXN) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_count);
        $display("RESULT: FAIL");
        $finish;
    end

    // out may only move on the cycle right before ack
    always @(negedge clk) begin
        if (rst_n) begin
            if (out_moved) begin
                assert (ack) else begin
                    $display("out changed to %h with no ack on the next cycle", out);
                    errors++;
                end
            end
            out_moved = !ack && (out != held_out);
            held_out  = out;
        end
    end

    // xorshift32
    function automatic logic [31:0] next_random();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic float_t random_normal();
        float_t      f;
        logic [31:0] r;
        r      = next_random();
        f.sign = r[31];
        f.frac = r[22:0];
        // keeps the product exponent normal
        f.exp  = 8'(64 + next_random() % 127);
        return f;
    endfunction

    task automatic check_out(input float_t expected, input float_t x, input float_t y);
        checks++;
        assert (out == expected) else begin
            $display("[FAIL] out = %h, expected %h (a = %h, b = %h)", out, expected, x, y);
            errors++;
        end
    endtask

    task automatic check_reset_state();
        checks++;
        assert (!ack && out == '0) else begin
            $display("[FAIL] ack = %h, out = %h, expected 0 and 00000000", ack, out);
            errors++;
        end
    endtask

    // edges after the capture edge until ack shows up
    task automatic wait_for_ack(output int edges);
        edges = 0;
        @(negedge clk);
        while (!ack && edges < CYCLES_PER_TXN) begin
            edges++;
            @(negedge clk);
        end
    endtask

    task automatic run_transaction(input float_t x, input float_t y, input logic zero_path);
        float_t expected;
        int     edges;
        expected = model_multiply(x, y);
        @(posedge clk);
        a   <= x;
        b   <= y;
        req <= 1'b1;
        @(posedge clk);
        req <= 1'b0;
        wait_for_ack(edges);
        checks++;
        assert (ack) else begin
            $display("no ack within %0d cycles of a request", CYCLES_PER_TXN);
            errors++;
        end
        if (ack) begin
            check_out(expected, x, y);
            if (zero_path) begin
                checks++;
                assert (edges == 2) else begin
                    $display("[FAIL] ack latency = %h, expected %h", edges, 2);
                    errors++;
                end
            end
            @(negedge clk);
            checks++;
            assert (!ack) else begin
                $display("[FAIL] ack = %h, expected %h one cycle after the pulse", ack, 1'b0);
                errors++;
            end
        end
    endtask

    // second req lands while b = 0x3faaaaab runs all 24 iterations
    task automatic busy_request_test();
        float_t expected;
        int     acks;
        expected = model_multiply(32'h3fc00000, 32'h3faaaaab);
        acks     = 0;
        @(posedge clk);
        a   <= 32'h3fc00000;
        b   <= 32'h3faaaaab;
        req <= 1'b1;
        @(posedge clk);
        req <= 1'b0;
        repeat (3) @(posedge clk);
        a   <= 32'h40400000;
        b   <= 32'h40a00000;
        req <= 1'b1;
        @(posedge clk);
        req <= 1'b0;
        repeat (CYCLES_PER_TXN) begin
            @(negedge clk);
            if (ack) begin
                acks++;
                check_out(expected, 32'h3fc00000, 32'h3faaaaab);
            end
        end
        checks++;
        assert (acks == 1) else begin
            $display("[FAIL] ack count = %h, expected %h", acks, 1);
            errors++;
        end
    endtask

    initial begin
        float_t x;
        float_t y;
        int     pick;
        rst_n = 1'b0;
        req   = 1'b0;
        a     = '0;
        b     = '0;
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            if (i == 9) begin
                rst_n <= 1'b1;
            end
            @(negedge clk);
            check_reset_state();
        end
        @(negedge clk);
        check_reset_state();

        // one or both exponent fields zero, fractions left random
        repeat (20) begin
            pick = int'(next_random() % 3);
            x    = random_normal();
            y    = random_normal();
            if (pick != 1) begin
                x.exp = '0;
            end
            if (pick != 0) begin
                y.exp = '0;
            end
            run_transaction(x, y, 1'b1);
        end

        run_transaction(real_to_single(1.0), real_to_single(1.0), 1'b0);
        run_transaction(real_to_single(1.1), real_to_single(1.1), 1'b0);
        run_transaction(real_to_single(2000.0), real_to_single(2.3), 1'b0);
        run_transaction(real_to_single(-2000.0), real_to_single(2.3), 1'b0);
        run_transaction(real_to_single(2000.0), real_to_single(-2.3), 1'b0);
        run_transaction(real_to_single(-2000.0), real_to_single(-2.3), 1'b0);
        run_transaction(real_to_single(200.0), real_to_single(100.0), 1'b0);

        repeat (250) begin
            run_transaction(random_normal(), random_normal(), 1'b0);
        end

        busy_request_test();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+include
+incdir+verification
logic/float_mul_pkg.sv
logic/float_mul_control.sv
logic/float_operand_decode.sv
logic/significand_shift_mul.sv
logic/float_normalize_pack.sv
logic/float_mul_pipeline.sv
verification/float_mul_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = float_mul_tb
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
